//--- verif/layerStim.txt
# op addr data resp, all but op in hex; W write, R read and compare, S start, P poll until done
# S and P use the control and status addresses, so addr is 0; P compares the final status word
W 000 0000000A 0
W 004 00000014 0
W 100 000000FB 0
W 144 00000064 0
W 180 00000003 0
W 200 0000FF9C 0
W 204 00007FFF 0
W 208 00000102 0
W 20C 000000A0 0
R 000 0000000A 0
R 100 000000FB 0
R 144 00000064 0
R 200 0000FF9C 0
R 208 00000102 0
S 0 00000001 0
W 180 0000007F 2
P 0 00000002 0
R 400 00000000 0
R 404 0000007F 0
R 408 00000005 0
R 40C 00000003 0
W 400 00000055 2
R 500 00000000 2
W 500 00000001 2
W 000 00000020 0
S 0 00000001 0
P 0 00000002 0
R 400 00000000 0
R 404 0000007F 0
R 408 00000006 0
R 40C 00000003 0

//--- filelist.f
hw/nnPkg.sv
hw/macUnit.sv
hw/reluQuant.sv
hw/layerCtrl.sv
hw/axiLiteRegs.sv
hw/nnLayerTop.sv
verif/nnLayerTb.sv

//--- run.sh
#!/bin/sh
# builds the layer testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module nnLayerTb -f filelist.f \
	&& ./obj_dir/VnnLayerTb 2>&1 | tee /dev/stderr | grep -q "^Verification passed$" \
	&& echo "run.sh: simulation ok" \
	|| { echo "run.sh: simulation not ok"; exit 1; }

//--- verif/nnLayerTb.sv
`timescale 1ns/1ps

module nnLayerTb import nnPkg::*; ();

	logic clk;
	logic reset;
	logic [axiAddrW-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [axiDataW-1:0] wdata;
	logic [axiDataW/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [axiAddrW-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [axiDataW-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	// one entry per bus operation of the stim file.
	logic [7:0] opQ [$];
	logic [axiAddrW-1:0] addrQ [$];
	logic [axiDataW-1:0] dataQ [$];
	logic [1:0] respQ [$];
	int cycleCnt;
	int cycleLimit;

	nnLayerTop i_nnLayerTop (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCnt <= cycleCnt + 1;
		if (cycleLimit != 0 && cycleCnt > cycleLimit)
		begin
			$display("Timeout: the stimulus did not finish within %0d cycles", cycleLimit);
			$display("Verification failed");
			$fatal(1);
		end
	end

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Error: %s = %h, expected %h", name, got, exp);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	task automatic loadStim();
		int fd;
		int code;
		int pollCount;
		logic [8*8-1:0] tok;
		logic [8*200-1:0] restOfLine;
		logic [axiAddrW-1:0] a;
		logic [axiDataW-1:0] d;
		logic [1:0] r;
		pollCount = 0;
		fd = $fopen("verif/layerStim.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the stimulus file verif/layerStim.txt");
			$display("Verification failed");
			$fatal(1);
		end
		while (!$feof(fd))
		begin
			code = $fscanf(fd, "%s", tok);
			if (code != 1)
				break;
			if (tok == "#")
				void'($fgets(restOfLine, fd)); // comment line.
			else
			begin
				code = $fscanf(fd, "%h %h %h", a, d, r);
				if (code != 3)
				begin
					$display("Malformed line for opcode %s in the stimulus file", tok[7:0]);
					$display("Verification failed");
					$fatal(1);
				end
				opQ.push_back(tok[7:0]);
				addrQ.push_back(a);
				dataQ.push_back(d);
				respQ.push_back(r);
				if (tok == "P")
					pollCount++;
			end
		end
		$fclose(fd);
		cycleLimit = 30 * opQ.size() + 200 * pollCount;
	endtask

	task automatic axiWrite(input logic [axiAddrW-1:0] addr, input logic [axiDataW-1:0] data,
		output logic [1:0] resp);
		int unsigned waitCycles;
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wstrb <= '1;
		wvalid <= 1'b1;
		do
			@(posedge clk);
		while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		waitCycles = $urandom % 4; // response back-pressure.
		repeat (waitCycles) @(posedge clk);
		bready <= 1'b1;
		do
			@(posedge clk);
		while (!bvalid);
		resp = bresp;
		bready <= 1'b0;
	endtask

	task automatic axiRead(input logic [axiAddrW-1:0] addr, output logic [axiDataW-1:0] data,
		output logic [1:0] resp);
		int unsigned waitCycles;
		araddr <= addr;
		arvalid <= 1'b1;
		do
			@(posedge clk);
		while (!arready);
		arvalid <= 1'b0;
		waitCycles = $urandom % 4;
		repeat (waitCycles) @(posedge clk);
		rready <= 1'b1;
		do
			@(posedge clk);
		while (!rvalid);
		data = rdata;
		resp = rresp;
		rready <= 1'b0;
	endtask

	task automatic runOp(input logic [7:0] op, input logic [axiAddrW-1:0] addr,
		input logic [axiDataW-1:0] data, input logic [1:0] resp);
		logic [axiDataW-1:0] got;
		logic [1:0] gotResp;
		case (op)
			"W":
			begin
				axiWrite(addr, data, gotResp);
				checkValue($sformatf("bresp@%h", addr), gotResp, resp);
			end
			"R":
			begin
				axiRead(addr, got, gotResp);
				checkValue($sformatf("rresp@%h", addr), gotResp, resp);
				checkValue($sformatf("rdata@%h", addr), got, data);
			end
			"S":
			begin
				axiWrite(ctrlAddr, data, gotResp);
				checkValue("bresp@start", gotResp, resp);
			end
			"P":
			begin
				do
				begin
					axiRead(statusAddr, got, gotResp);
					checkValue("rresp@status", gotResp, resp);
				end
				while (!got[1]); // wait for done.
				checkValue("status", got, data);
			end
			default:
			begin
				$display("Unknown opcode %s in the stimulus file", op);
				$display("Verification failed");
				$fatal(1);
			end
		endcase
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		cycleCnt = 0;
		cycleLimit = 0;
		void'($urandom(47946));
		loadStim();
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		for (int k = 0; k < opQ.size(); k++)
			runOp(opQ[k], addrQ[k], dataQ[k], respQ[k]);
		$display("Verification passed");
		$finish;
	end

endmodule

//--- hw/nnLayerTop.sv
`timescale 1ns/1ps

module nnLayerTop import nnPkg::*; (
	input logic clk,
	input logic reset,
	input logic [axiAddrW-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [axiDataW-1:0] wdata,
	input logic [axiDataW/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [axiAddrW-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [axiDataW-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);

	logic start;
	logic busy;
	logic [idxW-1:0] inIdx;
	logic [neuronW-1:0] neuronIdx;
	logic clear;
	logic macValid;
	logic quantize;
	logic resultWe;
	logic signed [actW-1:0] act;
	logic signed [wgtW-1:0] wgt;
	logic signed [biasW-1:0] bias;
	logic signed [accW-1:0] acc;
	logic [actW-1:0] result;

	axiLiteRegs i_axiLiteRegs (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.busy(busy), .inIdx(inIdx), .neuronIdx(neuronIdx),
		.resultWe(resultWe), .result(result),
		.start(start), .act(act), .wgt(wgt), .bias(bias)
	);

	layerCtrl i_layerCtrl (
		.clk(clk), .reset(reset), .start(start),
		.busy(busy), .inIdx(inIdx), .neuronIdx(neuronIdx),
		.clear(clear), .macValid(macValid), .quantize(quantize), .resultWe(resultWe)
	);

	// one mac shared by all neurons in turn.
	macUnit i_macUnit (
		.clk(clk), .reset(reset), .clear(clear), .macValid(macValid),
		.act(act), .wgt(wgt), .bias(bias), .acc(acc)
	);

	reluQuant i_reluQuant (
		.clk(clk), .reset(reset), .quantize(quantize), .acc(acc), .result(result)
	);

endmodule

//--- hw/axiLiteRegs.sv
`timescale 1ns/1ps

module axiLiteRegs import nnPkg::*; (
	input logic clk,
	input logic reset,
	input logic [axiAddrW-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [axiDataW-1:0] wdata,
	input logic [axiDataW/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [axiAddrW-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [axiDataW-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	input logic busy,
	input logic [idxW-1:0] inIdx,
	input logic [neuronW-1:0] neuronIdx,
	input logic resultWe,
	input logic [actW-1:0] result,
	output logic start,
	output logic signed [actW-1:0] act,
	output logic signed [wgtW-1:0] wgt,
	output logic signed [biasW-1:0] bias
);

	typedef enum logic [2:0] {rgNone, rgAct, rgWgt, rgBias, rgCtrl, rgStatus, rgResult} regionT;

	// raw bits as written, read back zero-extended.
	logic [actW-1:0] actMem [numIn];
	logic [wgtW-1:0] wgtMem [numNeurons][numIn];
	logic [biasW-1:0] biasMem [numNeurons];
	logic [actW-1:0] resultMem [numNeurons];
	logic done;

	regionT wRegion, rRegion;
	logic wrFire, rdFire;
	logic [axiDataW-1:0] rdWord;
	logic [1:0] rdResp;

	function automatic regionT decodeAddr(input logic [axiAddrW-1:0] addr);
		regionT rg;
		rg = rgNone;
		if (addr[11:8] == actBase[11:8] && addr[7:6] == 2'd0 && addr[5:2] < numIn)
			rg = rgAct;
		else if (addr[11:8] == wgtBase[11:8] && addr[5:2] < numIn)
			rg = rgWgt; // slot 15 of each row is a hole.
		else if (addr[11:8] == biasBase[11:8] && addr[7:4] == 4'd0)
			rg = rgBias;
		else if (addr == ctrlAddr)
			rg = rgCtrl;
		else if (addr == statusAddr)
			rg = rgStatus;
		else if (addr[11:8] == resultBase[11:8] && addr[7:4] == 4'd0)
			rg = rgResult;
		return rg;
	endfunction

	assign wRegion = decodeAddr(awaddr);
	assign rRegion = decodeAddr(araddr);
	assign wrFire = awvalid && awready && wvalid && wready;
	assign rdFire = arvalid && arready;

	// operands for the shared datapath.
	assign act = actMem[inIdx];
	assign wgt = wgtMem[neuronIdx][inIdx];
	assign bias = biasMem[neuronIdx];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= respOkay;
			start <= 1'b0;
			for (int i = 0; i < numIn; i++)
				actMem[i] <= '0;
			for (int n = 0; n < numNeurons; n++)
			begin
				biasMem[n] <= '0;
				for (int i = 0; i < numIn; i++)
					wgtMem[n][i] <= '0;
			end
		end
		else
		begin
			start <= 1'b0;
			awready <= !bvalid && !awready && awvalid && wvalid; // one-cycle accept pulse.
			wready <= !bvalid && !awready && awvalid && wvalid;
			if (wrFire)
			begin
				bvalid <= 1'b1;
				bresp <= respOkay;
				case (wRegion)
					rgAct:
						if (busy)
							bresp <= respSlvErr;
						else
							actMem[awaddr[5:2]] <= wdata[actW-1:0];
					rgWgt:
						if (busy)
							bresp <= respSlvErr;
						else
							wgtMem[awaddr[7:6]][awaddr[5:2]] <= wdata[wgtW-1:0];
					rgBias:
						if (busy)
							bresp <= respSlvErr;
						else
							biasMem[awaddr[neuronW+1:2]] <= wdata[biasW-1:0];
					rgCtrl: start <= wdata[0]; // controller drops it when busy.
					default: bresp <= respSlvErr;
				endcase
			end
			else if (bvalid && bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			done <= 1'b0;
			for (int n = 0; n < numNeurons; n++)
				resultMem[n] <= '0;
		end
		else
		begin
			if (resultWe)
				resultMem[neuronIdx] <= result;
			if (start)
				done <= 1'b0;
			else if (resultWe && neuronIdx == neuronW'(numNeurons - 1))
				done <= 1'b1;
		end
	end

	always_comb
	begin
		rdWord = '0;
		rdResp = respOkay;
		case (rRegion)
			rgAct: rdWord = axiDataW'(actMem[araddr[5:2]]);
			rgWgt: rdWord = axiDataW'(wgtMem[araddr[7:6]][araddr[5:2]]);
			rgBias: rdWord = axiDataW'(biasMem[araddr[neuronW+1:2]]);
			rgCtrl: rdWord = '0; // write only.
			rgStatus: rdWord = axiDataW'({done, busy});
			rgResult: rdWord = axiDataW'(resultMem[araddr[neuronW+1:2]]);
			default: rdResp = respSlvErr;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rdata <= '0;
			rresp <= respOkay;
		end
		else
		begin
			arready <= !rvalid && !arready && arvalid;
			if (rdFire)
			begin
				rvalid <= 1'b1;
				rdata <= rdWord;
				rresp <= rdResp;
			end
			else if (rvalid && rready)
				rvalid <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp));
	assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));
	// partial writes are not supported.
	assert property (@(posedge clk) disable iff (reset)
		wvalid && wready |-> wstrb == '1);

endmodule

//--- hw/layerCtrl.sv
`timescale 1ns/1ps

module layerCtrl import nnPkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	output logic busy,
	output logic [idxW-1:0] inIdx,
	output logic [neuronW-1:0] neuronIdx,
	output logic clear,
	output logic macValid,
	output logic quantize,
	output logic resultWe
);

	typedef enum logic [2:0] {sIdle, sClear, sAccum, sDrain, sQuant, sWrite} stateT;

	stateT state;
	logic drainCnt;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= sIdle;
			inIdx <= '0;
			neuronIdx <= '0;
			drainCnt <= 1'b0;
		end
		else
		begin
			case (state)
				sIdle:
					if (start)
					begin
						state <= sClear;
						inIdx <= '0;
						neuronIdx <= '0;
					end
				sClear: state <= sAccum; // bias preload.
				sAccum:
					if (inIdx == idxW'(numIn - 1))
					begin
						inIdx <= '0;
						drainCnt <= 1'b0;
						state <= sDrain;
					end
					else
						inIdx <= inIdx + 1'b1;
				sDrain:
				begin
					// two cycles to flush the product register into acc.
					drainCnt <= 1'b1;
					if (drainCnt)
						state <= sQuant;
				end
				sQuant: state <= sWrite;
				sWrite:
					if (neuronIdx == neuronW'(numNeurons - 1))
						state <= sIdle;
					else
					begin
						neuronIdx <= neuronIdx + 1'b1;
						state <= sClear;
					end
				default: state <= sIdle;
			endcase
		end
	end

	assign busy = state != sIdle;
	assign clear = state == sClear;
	assign macValid = state == sAccum;
	assign quantize = state == sQuant;
	assign resultWe = state == sWrite;

	assert property (@(posedge clk) disable iff (reset) !(clear && macValid));

endmodule

//--- hw/reluQuant.sv
`timescale 1ns/1ps

module reluQuant import nnPkg::*; (
	input logic clk,
	input logic reset,
	input logic quantize,
	input logic signed [accW-1:0] acc,
	output logic [actW-1:0] result
);

	logic [accW:0] rounded;
	logic [accW-fracShift:0] scaled;

	// extra top bit keeps the rounding carry from wrapping.
	assign rounded = {1'b0, acc} + (accW + 1)'(1 << (fracShift - 1));
	assign scaled = rounded[accW:fracShift];

	always_ff @(posedge clk)
	begin
		if (reset)
			result <= '0;
		else if (quantize)
		begin
			if (acc[accW-1])
				result <= '0; // relu.
			else if (scaled > outMax)
				result <= actW'(outMax);
			else
				result <= scaled[actW-1:0];
		end
	end

endmodule

//--- hw/macUnit.sv
`timescale 1ns/1ps

module macUnit import nnPkg::*; (
	input logic clk,
	input logic reset,
	input logic clear,
	input logic macValid,
	input logic signed [actW-1:0] act,
	input logic signed [wgtW-1:0] wgt,
	input logic signed [biasW-1:0] bias,
	output logic signed [accW-1:0] acc
);

	logic signed [prodW-1:0] prod;
	logic prodValid;

	// stage 1 registers the product, stage 2 accumulates.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			prod <= '0;
			prodValid <= 1'b0;
			acc <= '0;
		end
		else
		begin
			prodValid <= macValid;
			if (macValid)
				prod <= act * wgt;
			if (clear)
				acc <= {{(accW - biasW){bias[biasW-1]}}, bias};
			else if (prodValid)
				acc <= acc + {{(accW - prodW){prod[prodW-1]}}, prod};
		end
	end

endmodule

//--- hw/nnPkg.sv
package nnPkg;

	// layer geometry.
	localparam int numIn = 15;
	localparam int numNeurons = 4;

	localparam int actW = 8;
	localparam int wgtW = 8;
	localparam int biasW = 16;
	localparam int prodW = 16;
	localparam int accW = 23; // fifteen products plus bias, no overflow.
	localparam int idxW = 4;
	localparam int neuronW = 2;

	// output quantization.
	localparam int fracShift = 6;
	localparam int outMax = 127;

	localparam int axiAddrW = 12;
	localparam int axiDataW = 32;

	// byte addresses of the register map.
	localparam logic [axiAddrW-1:0] actBase = 12'h000;
	localparam logic [axiAddrW-1:0] wgtBase = 12'h100; // row of 16 words per neuron.
	localparam logic [axiAddrW-1:0] biasBase = 12'h200;
	localparam logic [axiAddrW-1:0] ctrlAddr = 12'h300;
	localparam logic [axiAddrW-1:0] statusAddr = 12'h304;
	localparam logic [axiAddrW-1:0] resultBase = 12'h400;

	localparam logic [1:0] respOkay = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;

endpackage
